/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_rv_pipeline_cpu
FILELIST := build.f
OBJDIR   := obj_dir

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

/* build.f */
rv_pkg.sv
rv_hazard_if.sv
rv_hazard_unit.sv
rv_stage_reg.sv
rv_decoder.sv
rv_regfile.sv
rv_execute_unit.sv
rv_pipeline_cpu.sv
tb_rv_pipeline_cpu.sv

/* rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
  input  wire rv_pkg::xlen_t instr,
  output rv_pkg::ctrl_t      ctrl,
  output rv_pkg::xlen_t      imm
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct7_5;
  rv_pkg::alu_op_e alu_sel;
  rv_pkg::xlen_t   imm_i;
  rv_pkg::xlen_t   imm_s;
  rv_pkg::xlen_t   imm_b;
  rv_pkg::xlen_t   imm_u;
  rv_pkg::xlen_t   imm_j;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by OP and OP-IMM
  // Sub only exists in register form
  always_comb begin
    case (funct3)
      3'b000:  alu_sel = (opcode == rv_pkg::OPC_OP && funct7_5) ? rv_pkg::ALU_SUB
                                                                 : rv_pkg::ALU_ADD;
      3'b001:  alu_sel = rv_pkg::ALU_SLL;
      3'b010:  alu_sel = rv_pkg::ALU_SLT;
      3'b011:  alu_sel = rv_pkg::ALU_SLTU;
      3'b100:  alu_sel = rv_pkg::ALU_XOR;
      3'b101:  alu_sel = funct7_5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  alu_sel = rv_pkg::ALU_OR;
      default: alu_sel = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        ctrl.alu_op    = rv_pkg::ALU_PASS_B;
        ctrl.src_b     = rv_pkg::SRC_B_IMM;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      rv_pkg::OPC_OP: begin
        ctrl.alu_op    = alu_sel;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        ctrl.alu_op    = alu_sel;
        ctrl.src_b     = rv_pkg::SRC_B_IMM;
        ctrl.reg_write = 1'b1;
        imm            = imm_i;
      end
      rv_pkg::OPC_LOAD: begin
        ctrl.src_b      = rv_pkg::SRC_B_IMM;
        ctrl.result_src = rv_pkg::RES_MEM;
        ctrl.reg_write  = 1'b1;
        imm             = imm_i;
      end
      rv_pkg::OPC_STORE: begin
        ctrl.src_b     = rv_pkg::SRC_B_IMM;
        ctrl.mem_write = 1'b1;
        imm            = imm_s;
      end
      rv_pkg::OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      rv_pkg::OPC_JAL: begin
        ctrl.src_a      = rv_pkg::SRC_A_PC;
        ctrl.src_b      = rv_pkg::SRC_B_IMM;
        ctrl.result_src = rv_pkg::RES_PC4;
        ctrl.reg_write  = 1'b1;
        ctrl.is_jal     = 1'b1;
        imm             = imm_j;
      end
      rv_pkg::OPC_JALR: begin
        ctrl.src_b      = rv_pkg::SRC_B_IMM;
        ctrl.result_src = rv_pkg::RES_PC4;
        ctrl.reg_write  = 1'b1;
        ctrl.is_jalr    = 1'b1;
        imm             = imm_i;
      end
      // Unknown opcode stays a NOP
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* rv_execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_execute_unit (
  input  wire rv_pkg::ex_payload_t ex,
  input  wire rv_pkg::fwd_sel_e    fwd_a,
  input  wire rv_pkg::fwd_sel_e    fwd_b,
  input  wire rv_pkg::xlen_t       result_m,
  input  wire rv_pkg::xlen_t       result_w,
  output rv_pkg::xlen_t            alu_result,
  output rv_pkg::xlen_t            store_data,
  output logic                     redirect,
  output rv_pkg::xlen_t            target
);

  rv_pkg::xlen_t opnd_a;
  rv_pkg::xlen_t opnd_b;
  rv_pkg::xlen_t alu_a;
  rv_pkg::xlen_t alu_b;
  rv_pkg::xlen_t target_sum;
  logic          taken;

  function automatic rv_pkg::xlen_t fwd_mux(
    input rv_pkg::fwd_sel_e sel,
    input rv_pkg::xlen_t    reg_val,
    input rv_pkg::xlen_t    from_m,
    input rv_pkg::xlen_t    from_w
  );
    case (sel)
      rv_pkg::FWD_MEM: return from_m;
      rv_pkg::FWD_WB:  return from_w;
      default:         return reg_val;
    endcase
  endfunction

  assign opnd_a = fwd_mux(fwd_a, ex.rd1, result_m, result_w);
  assign opnd_b = fwd_mux(fwd_b, ex.rd2, result_m, result_w);

  assign alu_a = (ex.ctrl.src_a == rv_pkg::SRC_A_PC) ? ex.pc : opnd_a;
  assign alu_b = (ex.ctrl.src_b == rv_pkg::SRC_B_IMM) ? ex.imm : opnd_b;

  always_comb begin
    case (ex.ctrl.alu_op)
      rv_pkg::ALU_SUB:    alu_result = alu_a - alu_b;
      rv_pkg::ALU_SLL:    alu_result = alu_a << alu_b[4:0];
      rv_pkg::ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      rv_pkg::ALU_SLTU:   alu_result = {31'b0, alu_a < alu_b};
      rv_pkg::ALU_XOR:    alu_result = alu_a ^ alu_b;
      rv_pkg::ALU_SRL:    alu_result = alu_a >> alu_b[4:0];
      rv_pkg::ALU_SRA:    alu_result = $signed(alu_a) >>> alu_b[4:0];
      rv_pkg::ALU_OR:     alu_result = alu_a | alu_b;
      rv_pkg::ALU_AND:    alu_result = alu_a & alu_b;
      rv_pkg::ALU_PASS_B: alu_result = alu_b;
      default:            alu_result = alu_a + alu_b;
    endcase
  end

  // Branch condition on the forwarded register values
  always_comb begin
    case (ex.funct3)
      3'b000:  taken = opnd_a == opnd_b;
      3'b001:  taken = opnd_a != opnd_b;
      3'b100:  taken = $signed(opnd_a) < $signed(opnd_b);
      3'b101:  taken = $signed(opnd_a) >= $signed(opnd_b);
      3'b110:  taken = opnd_a < opnd_b;
      3'b111:  taken = opnd_a >= opnd_b;
      default: taken = 1'b0;
    endcase
  end

  assign redirect   = (ex.ctrl.is_branch && taken) || ex.ctrl.is_jal || ex.ctrl.is_jalr;
  assign target_sum = (ex.ctrl.is_jalr ? opnd_a : ex.pc) + ex.imm;
  // JALR drops bit 0
  assign target     = ex.ctrl.is_jalr ? {target_sum[31:1], 1'b0} : target_sum;
  assign store_data = opnd_b;

endmodule

`default_nettype wire

/* rv_hazard_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface rv_hazard_if (
  input wire clk
);
  rv_pkg::reg_addr_t rs1_d;
  rv_pkg::reg_addr_t rs2_d;
  rv_pkg::reg_addr_t rs1_e;
  rv_pkg::reg_addr_t rs2_e;
  rv_pkg::reg_addr_t rd_e;
  logic              load_e;
  rv_pkg::reg_addr_t rd_m;
  logic              reg_write_m;
  rv_pkg::reg_addr_t rd_w;
  logic              reg_write_w;
  logic              redirect_e;

  // Back to the pipeline
  rv_pkg::fwd_sel_e  fwd_a;
  rv_pkg::fwd_sel_e  fwd_b;
  logic              stall_f;
  logic              stall_d;
  logic              flush_d;
  logic              flush_e;

  modport hazard (
    input  clk, rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e,
    input  rd_m, reg_write_m, rd_w, reg_write_w, redirect_e,
    output fwd_a, fwd_b, stall_f, stall_d, flush_d, flush_e
  );

  modport pipe (
    input  clk,
    output rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e,
    output rd_m, reg_write_m, rd_w, reg_write_w, redirect_e,
    input  fwd_a, fwd_b, stall_f, stall_d, flush_d, flush_e
  );
endinterface

`default_nettype wire

/* rv_hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_unit (
  rv_hazard_if.hazard hz
);

  logic load_use;

  // Memory stage wins over writeback and x0 is never forwarded
  function automatic rv_pkg::fwd_sel_e pick_fwd(
    input rv_pkg::reg_addr_t rs,
    input rv_pkg::reg_addr_t rd_m,
    input logic              we_m,
    input rv_pkg::reg_addr_t rd_w,
    input logic              we_w
  );
    rv_pkg::fwd_sel_e sel;
    sel = rv_pkg::FWD_NONE;
    if (rs != '0 && we_m && rs == rd_m) begin
      sel = rv_pkg::FWD_MEM;
    end else if (rs != '0 && we_w && rs == rd_w) begin
      sel = rv_pkg::FWD_WB;
    end
    return sel;
  endfunction

  assign hz.fwd_a = pick_fwd(hz.rs1_e, hz.rd_m, hz.reg_write_m, hz.rd_w, hz.reg_write_w);
  assign hz.fwd_b = pick_fwd(hz.rs2_e, hz.rd_m, hz.reg_write_m, hz.rd_w, hz.reg_write_w);

  // Load in execute feeding the instruction in decode
  assign load_use = hz.load_e && hz.rd_e != '0 &&
                    (hz.rd_e == hz.rs1_d || hz.rd_e == hz.rs2_d);

  assign hz.stall_f = load_use;
  assign hz.stall_d = load_use;

  // Taken redirect kills the two younger stages
  assign hz.flush_d = hz.redirect_e;
  assign hz.flush_e = load_use || hz.redirect_e;

  // A held fetch PC would drop the redirect target
  a_no_stall_on_redirect: assert property (@(posedge hz.clk) !(hz.redirect_e && load_use))
    else $error("load-use stall coincides with a redirect");

endmodule

`default_nettype wire

/* rv_pipeline_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_pipeline_cpu #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  wire                clk,
  input  wire                rst_n,
  output rv_pkg::xlen_t      instr_addr,
  input  wire rv_pkg::xlen_t instr_data,
  output rv_pkg::xlen_t      data_addr,
  output rv_pkg::xlen_t      data_wdata,
  output logic               data_we,
  input  wire rv_pkg::xlen_t data_rdata
);

  rv_pkg::xlen_t        pc_f;
  rv_pkg::de_payload_t  de_next;
  rv_pkg::de_payload_t  de_q;
  rv_pkg::xlen_t        instr_d;
  rv_pkg::ctrl_t        ctrl_d;
  rv_pkg::xlen_t        imm_d;
  rv_pkg::xlen_t        rd1_d;
  rv_pkg::xlen_t        rd2_d;
  rv_pkg::ex_payload_t  ex_next;
  rv_pkg::ex_payload_t  ex_q;
  rv_pkg::xlen_t        alu_result_e;
  rv_pkg::xlen_t        store_data_e;
  rv_pkg::xlen_t        target_e;
  logic                 redirect_e;
  rv_pkg::mem_payload_t mem_next;
  rv_pkg::mem_payload_t mem_q;
  rv_pkg::xlen_t        result_m;
  rv_pkg::wb_payload_t  wb_next;
  rv_pkg::wb_payload_t  wb_q;
  rv_pkg::xlen_t        result_w;

  rv_hazard_if hz (.clk(clk));

  rv_hazard_unit u_hazard (.hz(hz.hazard));

  // Fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f <= RESET_PC;
    end else if (!hz.stall_f) begin
      pc_f <= redirect_e ? target_e : pc_f + 32'd4;
    end
  end

  assign instr_addr = pc_f;

  always_comb begin
    de_next.instr = instr_data;
    de_next.pc    = pc_f;
    de_next.valid = 1'b1;
  end

  rv_stage_reg #(.payload_t(rv_pkg::de_payload_t)) de_reg (
    .clk(clk), .rst_n(rst_n), .stall(hz.stall_d), .flush(hz.flush_d),
    .d(de_next), .q(de_q)
  );

  // An empty decode slot reads as a NOP
  assign instr_d = de_q.valid ? de_q.instr : rv_pkg::NOP_INSTR;

  rv_decoder u_decoder (.instr(instr_d), .ctrl(ctrl_d), .imm(imm_d));

  rv_regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .ra1(instr_d[19:15]), .ra2(instr_d[24:20]), .rd1(rd1_d), .rd2(rd2_d),
    .wa(wb_q.rd), .we(wb_q.reg_write), .wd(result_w)
  );

  always_comb begin
    ex_next.ctrl   = ctrl_d;
    ex_next.funct3 = instr_d[14:12];
    ex_next.rs1    = instr_d[19:15];
    ex_next.rs2    = instr_d[24:20];
    ex_next.rd     = instr_d[11:7];
    ex_next.rd1    = rd1_d;
    ex_next.rd2    = rd2_d;
    ex_next.imm    = imm_d;
    ex_next.pc     = de_q.pc;
  end

  rv_stage_reg #(.payload_t(rv_pkg::ex_payload_t)) ex_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(hz.flush_e),
    .d(ex_next), .q(ex_q)
  );

  // Execute
  rv_execute_unit u_execute (
    .ex(ex_q), .fwd_a(hz.fwd_a), .fwd_b(hz.fwd_b),
    .result_m(result_m), .result_w(result_w),
    .alu_result(alu_result_e), .store_data(store_data_e),
    .redirect(redirect_e), .target(target_e)
  );

  always_comb begin
    mem_next.result_src = ex_q.ctrl.result_src;
    mem_next.reg_write  = ex_q.ctrl.reg_write;
    mem_next.mem_write  = ex_q.ctrl.mem_write;
    mem_next.rd         = ex_q.rd;
    mem_next.alu_result = alu_result_e;
    mem_next.store_data = store_data_e;
    mem_next.pc_plus_4  = ex_q.pc + 32'd4;
  end

  rv_stage_reg #(.payload_t(rv_pkg::mem_payload_t)) mem_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
    .d(mem_next), .q(mem_q)
  );

  // Memory
  assign data_addr  = mem_q.alu_result;
  assign data_wdata = mem_q.store_data;
  assign data_we    = mem_q.mem_write;
  // Load data is never forwarded from here
  assign result_m   = (mem_q.result_src == rv_pkg::RES_PC4) ? mem_q.pc_plus_4
                                                           : mem_q.alu_result;

  always_comb begin
    wb_next.reg_write  = mem_q.reg_write;
    wb_next.rd         = mem_q.rd;
    wb_next.result_src = mem_q.result_src;
    wb_next.result_pre = result_m;
    wb_next.load_data  = data_rdata;
  end

  rv_stage_reg #(.payload_t(rv_pkg::wb_payload_t)) wb_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
    .d(wb_next), .q(wb_q)
  );

  // Writeback
  assign result_w = (wb_q.result_src == rv_pkg::RES_MEM) ? wb_q.load_data : wb_q.result_pre;

  // Hazard unit inputs
  assign hz.rs1_d       = instr_d[19:15];
  assign hz.rs2_d       = instr_d[24:20];
  assign hz.rs1_e       = ex_q.rs1;
  assign hz.rs2_e       = ex_q.rs2;
  assign hz.rd_e        = ex_q.rd;
  assign hz.load_e      = ex_q.ctrl.result_src == rv_pkg::RES_MEM;
  assign hz.rd_m        = mem_q.rd;
  assign hz.reg_write_m = mem_q.reg_write;
  assign hz.rd_w        = wb_q.rd;
  assign hz.reg_write_w = wb_q.reg_write;
  assign hz.redirect_e  = redirect_e;

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // addi x0, x0, 0
  localparam xlen_t NOP_INSTR = 32'h0000_0013;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;
  typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_e;
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

  typedef struct packed {
    alu_op_e     alu_op;
    src_a_e      src_a;
    src_b_e      src_b;
    result_src_e result_src;
    logic        reg_write;
    logic        mem_write;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
  } ctrl_t;

  typedef struct packed {
    xlen_t instr;
    xlen_t pc;
    logic  valid;
  } de_payload_t;

  typedef struct packed {
    ctrl_t      ctrl;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    xlen_t      rd1;
    xlen_t      rd2;
    xlen_t      imm;
    xlen_t      pc;
  } ex_payload_t;

  // Only the controls still needed past execute
  typedef struct packed {
    result_src_e result_src;
    logic        reg_write;
    logic        mem_write;
    reg_addr_t   rd;
    xlen_t       alu_result;
    xlen_t       store_data;
    xlen_t       pc_plus_4;
  } mem_payload_t;

  typedef struct packed {
    logic        reg_write;
    reg_addr_t   rd;
    result_src_e result_src;
    xlen_t       result_pre;
    xlen_t       load_data;
  } wb_payload_t;

endpackage

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire rv_pkg::reg_addr_t ra1,
  input  wire rv_pkg::reg_addr_t ra2,
  output rv_pkg::xlen_t          rd1,
  output rv_pkg::xlen_t          rd2,
  input  wire rv_pkg::reg_addr_t wa,
  input  wire                    we,
  input  wire rv_pkg::xlen_t     wd
);

  rv_pkg::xlen_t regs [32];

  // Same-cycle write is visible to the reader
  function automatic rv_pkg::xlen_t read_port(input rv_pkg::reg_addr_t ra);
    if (ra == '0) begin
      return '0;
    end
    if (we && wa == ra) begin
      return wd;
    end
    return regs[ra];
  endfunction

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  always_comb begin
    rd1 = read_port(ra1);
    rd2 = read_port(ra2);
  end

  // Stored data comes back on the next read
  a_read_back: assert property (
    @(posedge clk) disable iff (!rst_n)
    (we && wa != '0) |=> (ra1 != $past(wa) || (we && wa == ra1) ||
                          rd1 == $past(wd))
  ) else $error("register read back differs from the data written");

endmodule

`default_nettype wire

/* rv_stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      stall,
  input  wire      flush,
  input  wire      payload_t d,
  output payload_t q
);

  // Flush has priority over stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

  a_hold: assert property (
    @(posedge clk) disable iff (!rst_n) (stall && !flush) |=> $stable(q)
  ) else $error("stage register changed while stalled");

endmodule

`default_nettype wire

/* tb_rv_pipeline_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_pipeline_cpu;

  localparam logic [31:0] RESET_PC  = 32'h0000_0000;
  localparam logic [31:0] NOP       = 32'h0000_0013;
  localparam logic [31:0] DONE_ADDR = 32'h0000_03fc;
  localparam logic [11:0] FALL_MARK = 12'h5a5;
  localparam logic [11:0] TAKE_MARK = 12'h0e7;
  localparam int          TIMEOUT   = 2000;

  // add sub xor or and sll sra srl slt sltu
  localparam logic [2:0] CHAIN_F3 [10] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7,
                                           3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
  localparam logic CHAIN_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                      1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        clear_ram;
  logic [31:0] instr_addr;
  logic [31:0] instr_data;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_we;
  logic [31:0] data_rdata;
  logic [31:0] rom [256];
  logic [31:0] ram [256];
  logic [7:0]  prog_len;
  integer      seed;

  rv_pipeline_cpu #(.RESET_PC(RESET_PC)) dut (
    .clk(clk), .rst_n(rst_n),
    .instr_addr(instr_addr), .instr_data(instr_data),
    .data_addr(data_addr), .data_wdata(data_wdata),
    .data_we(data_we), .data_rdata(data_rdata)
  );

  always #5 clk = ~clk;

  // Both memories answer in the same cycle
  assign instr_data = rom[instr_addr[9:2]];
  assign data_rdata = ram[data_addr[9:2]];

  always @(posedge clk) begin
    if (clear_ram) begin
      for (int i = 0; i < 256; i++) begin
        ram[i] <= fill_word(i[7:0]);
      end
    end else if (data_we) begin
      ram[data_addr[9:2]] <= data_wdata;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      check_value("instr_addr[1:0]", {30'b0, instr_addr[1:0]}, 32'h0);
    end
  end

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {16'hc0de, ~idx, idx};
  endfunction

  function automatic logic [31:0] r_type(input logic alt, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] hi);
    return {hi, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  // Reference results straight from the ISA definitions
  function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ram(input logic [31:0] addr, input logic [31:0] exp);
    check_value($sformatf("ram[0x%03h]", addr[9:0]), ram[addr[9:2]], exp);
  endtask

  task automatic check_reset_state();
    check_value("data_we", {31'b0, data_we}, 32'h0);
    check_value("instr_addr", instr_addr, RESET_PC);
  endtask

  task automatic emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len = prog_len + 8'd1;
  endtask

  // Core held in reset while the next program goes in
  task automatic begin_test();
    @(posedge clk);
    rst_n     <= 1'b0;
    clear_ram <= 1'b1;
    @(negedge clk);
    check_reset_state();
    for (int i = 0; i < 256; i++) begin
      rom[i] = NOP;
    end
    prog_len = '0;
  endtask

  task automatic run_program(input string name);
    int   cycles;
    logic done;
    // End marker store and a spin in place
    emit(sw(5'd0, 5'd0, DONE_ADDR[11:0]));
    emit(jal(5'd0, 21'd0));
    repeat (2) begin
      @(posedge clk);
      clear_ram <= 1'b0;
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state();
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk);
      done = data_we && data_addr == DONE_ADDR;
      cycles++;
    end
    assert (done) else begin
      $display("%s program never stored to the end address in %0d cycles", name, TIMEOUT);
      abort_run();
    end
  endtask

  task automatic test_alu_chain();
    logic [31:0] r;
    logic [31:0] x [13];
    begin_test();
    for (int k = 1; k <= 2; k++) begin
      r    = $random(seed);
      x[k] = {r[31:12], 12'h0} + {{20{r[11]}}, r[11:0]};
      emit(lui(k[4:0], r[31:12]));
      emit(addi(k[4:0], k[4:0], r[11:0]));
    end
    // rs1 one back and rs2 two back
    for (int k = 0; k < 10; k++) begin
      x[k+3] = alu_rule(CHAIN_F3[k], CHAIN_ALT[k], x[k+2], x[k+1]);
      emit(r_type(CHAIN_ALT[k], 5'(k + 1), 5'(k + 2), CHAIN_F3[k], 5'(k + 3)));
    end
    for (int k = 1; k <= 12; k++) begin
      emit(sw(5'(k), 5'd0, 12'(4 * k)));
    end
    run_program("alu chain");
    for (int k = 1; k <= 12; k++) begin
      check_ram(32'(4 * k), x[k]);
    end
  endtask

  task automatic test_load_use();
    logic [31:0] r;
    logic [31:0] v;
    logic [31:0] addend;
    begin_test();
    r      = $random(seed);
    v      = {r[31:12], 12'h0} + {{20{r[11]}}, r[11:0]};
    r      = $random(seed);
    addend = {{20{r[11]}}, r[11:0]};
    emit(lui(5'd1, v[31:12] + {19'b0, v[11]}));
    emit(addi(5'd1, 5'd1, v[11:0]));
    emit(addi(5'd2, 5'd0, addend[11:0]));
    emit(sw(5'd1, 5'd0, 12'h040));
    emit(lw(5'd3, 5'd0, 12'h040));
    emit(r_type(1'b0, 5'd2, 5'd3, 3'd0, 5'd4));
    emit(lw(5'd5, 5'd0, 12'h040));
    emit(r_type(1'b0, 5'd5, 5'd2, 3'd0, 5'd6));
    emit(sw(5'd4, 5'd0, 12'h044));
    emit(sw(5'd6, 5'd0, 12'h048));
    run_program("load use");
    check_ram(32'h040, v);
    check_ram(32'h044, v + addend);
    check_ram(32'h048, v + addend);
  endtask

  task automatic test_branches();
    logic [31:0] val [4];
    logic        taken [18];
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] slot;
    int          n;
    begin_test();
    val[1] = 32'hffff_fffb;
    val[2] = 32'd3;
    val[3] = 32'd3;
    emit(addi(5'd6, 5'd0, FALL_MARK));
    emit(addi(5'd7, 5'd0, TAKE_MARK));
    emit(addi(5'd1, 5'd0, val[1][11:0]));
    emit(addi(5'd2, 5'd0, val[2][11:0]));
    emit(addi(5'd3, 5'd0, val[3][11:0]));
    n = 0;
    for (int b = 0; b < 6; b++) begin
      for (int p = 0; p < 3; p++) begin
        f3       = (b < 2) ? 3'(b) : 3'(b + 2);
        rs1      = (p == 0) ? 5'd1 : 5'd2;
        rs2      = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
        slot     = 32'h100 + 32'(8 * n);
        taken[n] = branch_rule(f3, val[rs1], val[rs2]);
        // Fall-through store and a hop over the taken-path store
        emit(b_type(f3, rs1, rs2, 13'd12));
        emit(sw(5'd6, 5'd0, slot[11:0]));
        emit(jal(5'd0, 21'd8));
        emit(sw(5'd7, 5'd0, slot[11:0] + 12'd4));
        n++;
      end
    end
    run_program("branches");
    for (int i = 0; i < 18; i++) begin
      slot = 32'h100 + 32'(8 * i);
      if (taken[i]) begin
        check_ram(slot, fill_word(slot[9:2]));
        check_ram(slot + 32'd4, {20'b0, TAKE_MARK});
      end else begin
        check_ram(slot, {20'b0, FALL_MARK});
        check_ram(slot + 32'd4, fill_word(slot[9:2] + 8'd1));
      end
    end
  endtask

  task automatic test_jumps();
    logic [31:0] link [3];
    begin_test();
    emit(addi(5'd9, 5'd0, 12'h0bd));
    link[0] = {22'b0, prog_len, 2'b00} + 32'd4;
    emit(jal(5'd1, 21'd12));
    emit(sw(5'd9, 5'd0, 12'h200));
    emit(sw(5'd9, 5'd0, 12'h200));
    emit(sw(5'd1, 5'd0, 12'h204));
    // 42 + 3 is odd and lands on 44
    emit(addi(5'd2, 5'd0, 12'd42));
    link[1] = {22'b0, prog_len, 2'b00} + 32'd4;
    emit(jalr(5'd3, 5'd2, 12'd3));
    repeat (4) begin
      emit(sw(5'd9, 5'd0, 12'h200));
    end
    emit(sw(5'd3, 5'd0, 12'h208));
    link[2] = {22'b0, prog_len, 2'b00} + 32'd4;
    emit(jal(5'd4, 21'd8));
    emit(sw(5'd9, 5'd0, 12'h200));
    emit(sw(5'd4, 5'd0, 12'h20c));
    run_program("jumps");
    check_ram(32'h200, fill_word(8'h80));
    check_ram(32'h204, link[0]);
    check_ram(32'h208, link[1]);
    check_ram(32'h20c, link[2]);
  endtask

  task automatic test_x0_register();
    begin_test();
    emit(addi(5'd0, 5'd0, 12'h123));
    emit(sw(5'd0, 5'd0, 12'h300));
    emit(sw(5'd0, 5'd0, 12'h304));
    emit(r_type(1'b0, 5'd0, 5'd0, 3'd0, 5'd5));
    emit(sw(5'd5, 5'd0, 12'h308));
    run_program("x0");
    check_ram(32'h300, 32'h0);
    check_ram(32'h304, 32'h0);
    check_ram(32'h308, 32'h0);
  endtask

  initial begin
    rst_n     = 1'b0;
    clear_ram = 1'b1;
    seed      = 32'hfce0_f37d;
    prog_len  = '0;
    for (int i = 0; i < 256; i++) begin
      rom[i] = NOP;
    end
    test_alu_chain();
    test_load_use();
    test_branches();
    test_jumps();
    test_x0_register();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
